//--- hdc_core.f
+incdir+src
src/hdc_pkg.sv
src/hdc_csr.sv
src/hdc_inst_control.sv
src/hdc_inst_decode.sv
src/hdc_item_memory.sv
src/hdc_encoder.sv
src/hdc_top.sv
verification/hdc_properties.sv
verification/hdc_tb.sv

//--- verification/hdc_tb.sv
/*
  Testbench for the HDC encoder core. Loads programs over the CSR port,
  strobes random symbols and predicts every emitted query vector with a
  model of the instruction set. Emits are checked as they arrive.
*/
`timescale 1ns/1ps
`include "hdc_defs.svh"

module hdc_tb;

  import hdc_pkg::*;

  localparam int NUM_SYMS       = 68;
  localparam int MAX_PROG_END   = `HDC_INST_DEPTH - 1;
  localparam int TIMEOUT_CYCLES = NUM_SYMS * (MAX_PROG_END + 4) + 200;
  localparam int CNT_MAX        = (1 << (`HDC_BUND_W - 1)) - 1;
  localparam int CNT_MIN        = -(1 << (`HDC_BUND_W - 1));

  logic      clk;
  logic      rst;
  logic      csr_wr;
  logic      csr_rd;
  csr_addr_t csr_addr;
  csr_data_t csr_wdata;
  csr_data_t csr_rdata;
  logic      csr_rvalid;
  logic      sym_valid;
  sym_t      sym;
  hv_t       qhv;
  logic      qhv_valid;

  integer    seed;
  int        errors;
  int        tests;
  int        errs_before;
  int        prop_fails_seen;

  // Model state
  hv_t       m_regs [`HDC_NUM_REGS];
  int        m_cnt [`HDC_HV_DIM];
  csr_data_t m_prog [`HDC_INST_DEPTH];
  int        m_end;
  int        m_pc;
  hv_t       exp_q [$];
  csr_data_t prog_q [$];

  hdc_top dut_i (
    .clk_i        ( clk        ),
    .rst_i        ( rst        ),
    .csr_wr_i     ( csr_wr     ),
    .csr_rd_i     ( csr_rd     ),
    .csr_addr_i   ( csr_addr   ),
    .csr_wdata_i  ( csr_wdata  ),
    .csr_rdata_o  ( csr_rdata  ),
    .csr_rvalid_o ( csr_rvalid ),
    .sym_valid_i  ( sym_valid  ),
    .sym_i        ( sym        ),
    .qhv_o        ( qhv        ),
    .qhv_valid_o  ( qhv_valid  )
  );

  always #5 clk = ~clk;

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_hv(input string name, input hv_t got, input hv_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_csr(input string name, input csr_data_t got, input csr_data_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Assertion failures of the bound checker count as errors
  task automatic collect_property_failures();
    errors += dut_i.props_i.fail_count - prop_fails_seen;
    prop_fails_seen = dut_i.props_i.fail_count;
  endtask

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic hv_t item_of(sym_t s);
    hv_t v;
    v = `HDC_ITEM_SEED;
    for (int k = 0; k < s; k++) begin
      v = {v[`HDC_HV_DIM-2:0], v[`HDC_HV_DIM-1]};
    end
    return v;
  endfunction

  function automatic bit is_pop(csr_data_t w);
    return (w[2:0] == OP_LOAD_IM) || (w[2:0] == OP_BIND_IM);
  endfunction

  function automatic void exec_inst(csr_data_t w, hv_t item);
    int  dst;
    hv_t v;
    hv_t maj;
    dst = w[4:3];
    v   = m_regs[w[6:5]];
    maj = '0;
    case (w[2:0])
      OP_LOAD_IM:  m_regs[dst] = item;
      OP_BIND_IM:  m_regs[dst] = v ^ item;
      OP_BIND_REG: m_regs[dst] = m_regs[dst] ^ v;
      OP_PERM:     m_regs[dst] = {v[`HDC_HV_DIM-2:0], v[`HDC_HV_DIM-1]};
      OP_BUNDLE: begin
        for (int i = 0; i < `HDC_HV_DIM; i++) begin
          if (v[i] && m_cnt[i] < CNT_MAX) m_cnt[i]++;
          else if (!v[i] && m_cnt[i] > CNT_MIN) m_cnt[i]--;
        end
      end
      OP_EMIT: begin
        // Strictly positive count gives a 1, ties give 0
        for (int i = 0; i < `HDC_HV_DIM; i++) begin
          maj[i]   = (m_cnt[i] > 0);
          m_cnt[i] = 0;
        end
        exp_q.push_back(maj);
      end
      default: ;
    endcase
  endfunction

  function automatic void step_pc();
    m_pc = (m_pc == m_end) ? 0 : m_pc + 1;
  endfunction

  // Runs up to the next pop, where the core waits for a symbol
  function automatic void run_to_pop();
    int guard;
    guard = 0;
    while (!is_pop(m_prog[m_pc]) && guard < 64) begin
      exec_inst(m_prog[m_pc], '0);
      step_pc();
      guard++;
    end
  endfunction

  function automatic void consume(sym_t s);
    exec_inst(m_prog[m_pc], item_of(s));
    step_pc();
    run_to_pop();
  endfunction

  // Random filler above bit 6 is ignored by the decoder
  function automatic csr_data_t inst(hdc_op_e op, reg_addr_t dst, reg_addr_t src);
    csr_data_t w;
    w      = $random(seed);
    w[2:0] = op;
    w[4:3] = dst;
    w[6:5] = src;
    return w;
  endfunction

  // --------------------------------------------------------------------------
  // Bus and symbol drivers
  // --------------------------------------------------------------------------
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
    csr_wr    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    step();
    csr_wr = 1'b0;
  endtask

  task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
    csr_rd   = 1'b1;
    csr_addr = addr;
    step();
    csr_rd = 1'b0;
    if (csr_rvalid !== 1'b1) begin
      $display("%0d ns: csr_rvalid_o did not follow the read strobe", $time);
      errors++;
    end
    data = csr_rdata;
  endtask

  task automatic load_program();
    csr_write(`HDC_CSR_INST_ADDR, '0);
    foreach (prog_q[k]) begin
      csr_write(`HDC_CSR_INST_DATA, prog_q[k]);
      m_prog[k] = prog_q[k];
    end
    m_end = prog_q.size() - 1;
    csr_write(`HDC_CSR_PROG_END, csr_data_t'(m_end));
  endtask

  task automatic start_run();
    csr_write(`HDC_CSR_CTRL, 32'h1);
    run_to_pop();
  endtask

  // Extra cycle lets the run state settle before any STATUS read
  task automatic stop_run();
    csr_write(`HDC_CSR_CTRL, 32'h0);
    step();
  endtask

  task automatic clear_core();
    csr_write(`HDC_CSR_CTRL, 32'h2);
    step();
    foreach (m_regs[r]) m_regs[r] = '0;
    foreach (m_cnt[i]) m_cnt[i] = 0;
    m_pc = 0;
  endtask

  task automatic send_symbol(input sym_t s);
    sym_valid = 1'b1;
    sym       = s;
    step();
    sym_valid = 1'b0;
    consume(s);
    repeat (m_end + 2) step();
  endtask

  task automatic wait_emits();
    while (exp_q.size() != 0) step();
    repeat (4) step();
  endtask

  task automatic report_test(input string name);
    collect_property_failures();
    tests++;
    $display("Test %0d, %s: %s", tests, name, (errors == errs_before) ? "ok" : "FAILED");
    errs_before = errors;
  endtask

  // Every emit pulse is checked against the oldest prediction
  always @(posedge clk) begin
    if (!rst && qhv_valid) begin
      if (exp_q.size() == 0) begin
        $display("%0d ns: qhv_valid_o pulsed with no emit expected", $time);
        errors++;
      end else begin
        check_hv("qhv_o", qhv, exp_q.pop_front());
      end
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * 10);
    $display("Timeout after %0d cycles, the core stopped producing results",
             TIMEOUT_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    sym_t      s;
    sym_t      a;
    sym_t      b;
    int        n;
    int        j;
    reg_addr_t tmp;
    reg_addr_t r [4];
    csr_data_t rd;
    csr_data_t exp;

    clk       = 1'b0;
    rst       = 1'b1;
    csr_wr    = 1'b0;
    csr_rd    = 1'b0;
    csr_addr  = '0;
    csr_wdata = '0;
    sym_valid = 1'b0;
    sym       = '0;
    seed      = 90435;
    errors    = 0;
    tests     = 0;
    errs_before = 0;
    prop_fails_seen = 0;
    m_pc      = 0;
    m_end     = 0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    // Register readback after reset
    csr_read(`HDC_CSR_STATUS, rd);
    check_csr("STATUS", rd, '0);
    check_hv("qhv_o", qhv, '0);
    exp = csr_data_t'($unsigned($random(seed)) % 16);
    csr_write(`HDC_CSR_PROG_END, exp);
    csr_read(`HDC_CSR_PROG_END, rd);
    check_csr("PROG_END", rd, exp);
    exp = csr_data_t'($unsigned($random(seed)) % 16);
    csr_write(`HDC_CSR_INST_ADDR, exp);
    n = 1 + $unsigned($random(seed)) % 20;
    repeat (n) csr_write(`HDC_CSR_INST_DATA, $random(seed));
    csr_read(`HDC_CSR_INST_ADDR, rd);
    check_csr("INST_ADDR", rd, csr_data_t'((exp + n) % 16));
    report_test("csr readback");

    // Single item through the bundler
    clear_core();
    prog_q = {};
    prog_q.push_back(inst(OP_LOAD_IM, 2'd0, 2'd0));
    prog_q.push_back(inst(OP_BUNDLE, 2'd0, 2'd0));
    prog_q.push_back(inst(OP_EMIT, 2'd0, 2'd0));
    load_program();
    start_run();
    s = sym_t'($random(seed));
    send_symbol(s);
    wait_emits();
    stop_run();
    report_test("single item");

    // Majority of three, then ten of each of two symbols for ties
    for (int pass = 0; pass < 2; pass++) begin
      clear_core();
      prog_q = {};
      prog_q.push_back(inst(OP_LOAD_IM, 2'd1, 2'd0));
      prog_q.push_back(inst(OP_BUNDLE, 2'd0, 2'd1));
      load_program();
      start_run();
      a = sym_t'($random(seed));
      b = sym_t'(a + 1 + $unsigned($random(seed)) % 63);
      for (int k = 0; k < ((pass == 0) ? 3 : 20); k++) begin
        s = (pass == 0) ? sym_t'($random(seed)) : (k[0] ? b : a);
        send_symbol(s);
      end
      stop_run();
      // Emit program leaves the counters alone until the emit
      prog_q = {};
      prog_q.push_back(inst(OP_LOAD_IM, 2'd2, 2'd0));
      prog_q.push_back(inst(OP_EMIT, 2'd0, 2'd0));
      load_program();
      start_run();
      send_symbol(sym_t'($random(seed)));
      wait_emits();
      stop_run();
    end
    report_test("majority bundling");

    // Trigram over a random register assignment, unrolled twice
    clear_core();
    r = '{2'd0, 2'd1, 2'd2, 2'd3};
    for (int k = 3; k > 0; k--) begin
      j    = $unsigned($random(seed)) % (k + 1);
      tmp  = r[k];
      r[k] = r[j];
      r[j] = tmp;
    end
    prog_q = {};
    repeat (2) begin
      prog_q.push_back(inst(OP_PERM, r[2], r[1]));
      prog_q.push_back(inst(OP_PERM, r[1], r[0]));
      prog_q.push_back(inst(OP_LOAD_IM, r[0], r[0]));
      prog_q.push_back(inst(OP_BIND_REG, r[2], r[1]));
      prog_q.push_back(inst(OP_BIND_IM, r[3], r[2]));
      prog_q.push_back(inst(OP_BUNDLE, r[0], r[3]));
    end
    prog_q.push_back(inst(OP_EMIT, 2'd0, 2'd0));
    load_program();
    start_run();
    repeat (40) send_symbol(sym_t'($random(seed)));
    wait_emits();
    stop_run();
    report_test("trigram program");

    // Clear in the middle of a pass
    clear_core();
    prog_q = {};
    prog_q.push_back(inst(OP_LOAD_IM, 2'd0, 2'd0));
    prog_q.push_back(inst(OP_BUNDLE, 2'd0, 2'd0));
    prog_q.push_back(inst(OP_LOAD_IM, 2'd1, 2'd0));
    prog_q.push_back(inst(OP_BUNDLE, 2'd0, 2'd1));
    prog_q.push_back(inst(OP_EMIT, 2'd0, 2'd0));
    load_program();
    start_run();
    send_symbol(sym_t'($random(seed)));
    stop_run();
    exp      = '0;
    exp[7:4] = m_pc[3:0];
    csr_read(`HDC_CSR_STATUS, rd);
    check_csr("STATUS", rd, exp);
    clear_core();
    csr_read(`HDC_CSR_STATUS, rd);
    check_csr("STATUS", rd, '0);
    prog_q = {};
    prog_q.push_back(inst(OP_LOAD_IM, 2'd0, 2'd0));
    prog_q.push_back(inst(OP_BUNDLE, 2'd0, 2'd0));
    prog_q.push_back(inst(OP_EMIT, 2'd0, 2'd0));
    load_program();
    start_run();
    send_symbol(sym_t'($random(seed)));
    wait_emits();
    stop_run();
    report_test("clear pulse");

    collect_property_failures();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- verification/hdc_properties.sv
/*
  Concurrent checks on the top-level timing of the HDC core: single-cycle
  emit pulses, read data one cycle after the read strobe, quiet outputs
  during reset. Attached to hdc_top by the bind at the end of this file.
*/
`timescale 1ns/1ps

module hdc_properties (
  input logic clk_i,
  input logic rst_i,
  input logic csr_rd_i,
  input logic csr_rvalid_i,
  input logic qhv_valid_i
);

  int fail_count = 0;

  // Emit pulse lasts one cycle
  a_qhv_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    qhv_valid_i |=> !qhv_valid_i)
    else begin
      $error("qhv_valid_o stayed high for two cycles");
      fail_count++;
    end

  // Read data returns exactly one cycle after the strobe
  a_rvalid_set: assert property (@(posedge clk_i) disable iff (rst_i)
    csr_rd_i |=> csr_rvalid_i)
    else begin
      $error("csr_rvalid_o missing one cycle after csr_rd_i");
      fail_count++;
    end

  a_rvalid_clr: assert property (@(posedge clk_i) disable iff (rst_i)
    !csr_rd_i |=> !csr_rvalid_i)
    else begin
      $error("csr_rvalid_o high without a read strobe");
      fail_count++;
    end

  // Outputs held low through reset
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i |=> (!qhv_valid_i && !csr_rvalid_i))
    else begin
      $error("valid output high during reset");
      fail_count++;
    end

endmodule

bind hdc_top hdc_properties props_i (
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .csr_rd_i     ( csr_rd_i     ),
  .csr_rvalid_i ( csr_rvalid_o ),
  .qhv_valid_i  ( qhv_valid_o  )
);

//--- src/hdc_top.sv
/*
  Top level of the programmable HDC encoder core. Connects the host CSR
  port, instruction fetch and decode, the item memory and the encoder.
  One clock, one synchronous active-high reset.
*/
`timescale 1ns/1ps

module hdc_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                csr_wr_i,
  input  logic                csr_rd_i,
  input  hdc_pkg::csr_addr_t  csr_addr_i,
  input  hdc_pkg::csr_data_t  csr_wdata_i,
  output hdc_pkg::csr_data_t  csr_rdata_o,
  output logic                csr_rvalid_o,
  input  logic                sym_valid_i,
  input  hdc_pkg::sym_t       sym_i,
  output hdc_pkg::hv_t        qhv_o,
  output logic                qhv_valid_o
);

  import hdc_pkg::*;

  // CSR to control
  logic       run;
  logic       clr;
  inst_addr_t prog_end;
  logic       inst_we;
  inst_addr_t inst_waddr;
  csr_data_t  inst_wdata;
  logic       running;
  inst_addr_t pc;

  // Fetch, decode and item memory
  csr_data_t  inst_word;
  logic       exec_en;
  hdc_op_e    op;
  reg_addr_t  dst;
  reg_addr_t  src;
  logic       pop;
  hv_t        item_hv;
  logic       hold_full;

  hdc_csr i_csr (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .csr_wr_i     ( csr_wr_i     ),
    .csr_rd_i     ( csr_rd_i     ),
    .csr_addr_i   ( csr_addr_i   ),
    .csr_wdata_i  ( csr_wdata_i  ),
    .csr_rdata_o  ( csr_rdata_o  ),
    .csr_rvalid_o ( csr_rvalid_o ),
    .running_i    ( running      ),
    .pc_i         ( pc           ),
    .run_o        ( run          ),
    .clr_o        ( clr          ),
    .prog_end_o   ( prog_end     ),
    .inst_we_o    ( inst_we      ),
    .inst_waddr_o ( inst_waddr   ),
    .inst_wdata_o ( inst_wdata   )
  );

  hdc_inst_control i_inst_control (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .run_i        ( run          ),
    .clr_i        ( clr          ),
    .prog_end_i   ( prog_end     ),
    .inst_we_i    ( inst_we      ),
    .inst_waddr_i ( inst_waddr   ),
    .inst_wdata_i ( inst_wdata   ),
    .pop_i        ( pop          ),
    .hold_full_i  ( hold_full    ),
    .inst_word_o  ( inst_word    ),
    .exec_en_o    ( exec_en      ),
    .running_o    ( running      ),
    .pc_o         ( pc           )
  );

  hdc_inst_decode i_inst_decode (
    .inst_word_i  ( inst_word    ),
    .exec_en_i    ( exec_en      ),
    .op_o         ( op           ),
    .dst_o        ( dst          ),
    .src_o        ( src          ),
    .pop_o        ( pop          )
  );

  hdc_item_memory i_item_memory (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .clr_i        ( clr          ),
    .sym_valid_i  ( sym_valid_i  ),
    .sym_i        ( sym_i        ),
    .pop_i        ( pop          ),
    .item_hv_o    ( item_hv      ),
    .hold_full_o  ( hold_full    )
  );

  hdc_encoder i_encoder (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .clr_i        ( clr          ),
    .op_i         ( op           ),
    .dst_i        ( dst          ),
    .src_i        ( src          ),
    .item_hv_i    ( item_hv      ),
    .qhv_o        ( qhv_o        ),
    .qhv_valid_o  ( qhv_valid_o  )
  );

endmodule

//--- src/hdc_encoder.sv
/*
  HDC encoder datapath. Four hypervector registers, a bind and permute unit
  and one saturating signed bundling counter per bit. Applies the decoded
  operation each cycle; EMIT registers the majority vector, pulses
  qhv_valid_o for one cycle and clears the counters.
*/
`timescale 1ns/1ps
`include "hdc_defs.svh"

module hdc_encoder (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                clr_i,
  input  hdc_pkg::hdc_op_e    op_i,
  input  hdc_pkg::reg_addr_t  dst_i,
  input  hdc_pkg::reg_addr_t  src_i,
  input  hdc_pkg::hv_t        item_hv_i,
  output hdc_pkg::hv_t        qhv_o,
  output logic                qhv_valid_o
);

  import hdc_pkg::*;

  localparam int unsigned HV = `HDC_HV_DIM;
  localparam int unsigned BW = `HDC_BUND_W;
  localparam logic signed [BW-1:0] CNT_MAX = {1'b0, {(BW-1){1'b1}}};
  localparam logic signed [BW-1:0] CNT_MIN = {1'b1, {(BW-1){1'b0}}};

  hv_t                   regs_q [`HDC_NUM_REGS];
  hv_t                   src_hv;
  hv_t                   dst_hv;
  hv_t                   alu_res;
  logic                  alu_we;
  logic signed [BW-1:0]  cnt_q [HV];
  logic signed [BW-1:0]  cnt_d [HV];
  hv_t                   majority;
  hv_t                   qhv_q;
  logic                  qhv_valid_q;

  assign src_hv = regs_q[src_i];
  assign dst_hv = regs_q[dst_i];

  // --------------------------------------------------------------------------
  // Bind and permute
  // --------------------------------------------------------------------------
  always_comb begin
    alu_res = '0;
    alu_we  = 1'b0;
    case (op_i)
      OP_LOAD_IM: begin
        alu_res = item_hv_i;
        alu_we  = 1'b1;
      end
      OP_BIND_IM: begin
        alu_res = src_hv ^ item_hv_i;
        alu_we  = 1'b1;
      end
      OP_BIND_REG: begin
        alu_res = dst_hv ^ src_hv;
        alu_we  = 1'b1;
      end
      OP_PERM: begin
        // Rotate left by one
        alu_res = {src_hv[HV-2:0], src_hv[HV-1]};
        alu_we  = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || clr_i) begin
      for (int r = 0; r < `HDC_NUM_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (alu_we) begin
      regs_q[dst_i] <= alu_res;
    end
  end

  // --------------------------------------------------------------------------
  // Bundling counters and majority
  // --------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < HV; i++) begin
      cnt_d[i] = cnt_q[i];
      if (op_i == OP_EMIT) begin
        cnt_d[i] = '0;
      end else if (op_i == OP_BUNDLE) begin
        if (src_hv[i] && (cnt_q[i] != CNT_MAX)) begin
          cnt_d[i] = cnt_q[i] + 1'b1;
        end else if (!src_hv[i] && (cnt_q[i] != CNT_MIN)) begin
          cnt_d[i] = cnt_q[i] - 1'b1;
        end
      end
      // Ties give 0
      majority[i] = (cnt_q[i] > 0);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < HV; i++) begin
      if (rst_i || clr_i) begin
        cnt_q[i] <= '0;
      end else begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // Query output holds until the next emit
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      qhv_q       <= '0;
      qhv_valid_q <= 1'b0;
    end else begin
      qhv_valid_q <= (op_i == OP_EMIT) && !clr_i;
      if ((op_i == OP_EMIT) && !clr_i) begin
        qhv_q <= majority;
      end
    end
  end

  assign qhv_o       = qhv_q;
  assign qhv_valid_o = qhv_valid_q;

endmodule

//--- src/hdc_item_memory.sv
/*
  Seed-based item memory. Keeps one held symbol from the strobe input and
  presents its item hypervector, the seed rotated left by the symbol value.
  A strobe arriving while the hold is full is dropped.
*/
`timescale 1ns/1ps
`include "hdc_defs.svh"

module hdc_item_memory (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           clr_i,
  input  logic           sym_valid_i,
  input  hdc_pkg::sym_t  sym_i,
  input  logic           pop_i,
  output hdc_pkg::hv_t   item_hv_o,
  output logic           hold_full_o
);

  import hdc_pkg::*;

  sym_t                     sym_q;
  logic                     full_q;
  logic [2*`HDC_HV_DIM-1:0] seed_dbl;

  always_ff @(posedge clk_i) begin
    if (rst_i || clr_i) begin
      full_q <= 1'b0;
      sym_q  <= '0;
    end else if (sym_valid_i && !full_q) begin
      full_q <= 1'b1;
      sym_q  <= sym_i;
    end else if (pop_i && full_q) begin
      // Pop is only seen while running, so this is an executed consume
      full_q <= 1'b0;
    end
  end

  // Rotate by shifting a doubled copy and keeping the upper half
  assign seed_dbl  = {`HDC_ITEM_SEED, `HDC_ITEM_SEED} << sym_q;
  assign item_hv_o = seed_dbl[2*`HDC_HV_DIM-1:`HDC_HV_DIM];

  assign hold_full_o = full_q;

endmodule

//--- src/hdc_inst_decode.sv
/*
  Instruction decoder of the HDC encoder. Splits the fetched word into
  opcode, destination and source register fields. The opcode is forced to
  a no-op when execution is not enabled; pop flags the item opcodes.
*/
`timescale 1ns/1ps

module hdc_inst_decode (
  input  hdc_pkg::csr_data_t  inst_word_i,
  input  logic                exec_en_i,
  output hdc_pkg::hdc_op_e    op_o,
  output hdc_pkg::reg_addr_t  dst_o,
  output hdc_pkg::reg_addr_t  src_o,
  output logic                pop_o
);

  import hdc_pkg::*;

  logic [2:0] op_raw;
  hdc_op_e    op_dec;

  assign op_raw = inst_word_i[2:0];

  // Map the raw field onto the opcode set
  always_comb begin
    case (op_raw)
      3'd1:    op_dec = OP_LOAD_IM;
      3'd2:    op_dec = OP_BIND_IM;
      3'd3:    op_dec = OP_BIND_REG;
      3'd4:    op_dec = OP_PERM;
      3'd5:    op_dec = OP_BUNDLE;
      3'd6:    op_dec = OP_EMIT;
      default: op_dec = OP_NOP;
    endcase
  end

  // Symbol request comes from the word itself so a stall can be detected
  assign pop_o = (op_dec == OP_LOAD_IM) || (op_dec == OP_BIND_IM);

  assign op_o  = exec_en_i ? op_dec : OP_NOP;
  assign dst_o = inst_word_i[4:3];
  assign src_o = inst_word_i[6:5];

endmodule

//--- src/hdc_inst_control.sv
/*
  Instruction fetch of the HDC encoder. Holds the program memory, tracks
  the run state and steps the PC once per executed instruction, wrapping
  after PROG_END. A pop with no held symbol stalls the PC.
  Outside the run state the fetched word is forced to a no-op.
*/
`timescale 1ns/1ps
`include "hdc_defs.svh"

module hdc_inst_control (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  run_i,
  input  logic                  clr_i,
  input  hdc_pkg::inst_addr_t   prog_end_i,
  input  logic                  inst_we_i,
  input  hdc_pkg::inst_addr_t   inst_waddr_i,
  input  hdc_pkg::csr_data_t    inst_wdata_i,
  input  logic                  pop_i,
  input  logic                  hold_full_i,
  output hdc_pkg::csr_data_t    inst_word_o,
  output logic                  exec_en_o,
  output logic                  running_o,
  output hdc_pkg::inst_addr_t   pc_o
);

  import hdc_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } state_e;

  state_e     state_q;
  state_e     state_d;
  inst_addr_t pc_q;
  csr_data_t  inst_mem [`HDC_INST_DEPTH];
  logic       active;
  logic       stall;

  // --------------------------------------------------------------------------
  // Program memory
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (inst_we_i) begin
      inst_mem[inst_waddr_i] <= inst_wdata_i;
    end
  end

  // --------------------------------------------------------------------------
  // Run state
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (run_i) state_d = ST_RUN;
      ST_RUN:  if (!run_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Clear cycle executes nothing
  assign active = (state_q == ST_RUN) && run_i && !clr_i;

  // Only a real pop can stall, since idle words are no-ops
  assign stall     = pop_i && !hold_full_i;
  assign exec_en_o = active && !stall;

  assign inst_word_o = active ? inst_mem[pc_q] : '0;

  // --------------------------------------------------------------------------
  // Program counter
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || clr_i) begin
      pc_q <= '0;
    end else if (exec_en_o) begin
      if (pc_q == prog_end_i) begin
        pc_q <= '0;
      end else begin
        pc_q <= pc_q + 1'b1;
      end
    end
  end

  assign pc_o      = pc_q;
  assign running_o = (state_q == ST_RUN);

endmodule

//--- src/hdc_csr.sv
/*
  Host register file of the HDC encoder. Single-cycle write and read strobes;
  read data returns one cycle after the read strobe with csr_rvalid_o.
  Drives the run bit, the clear pulse, PROG_END and the program write path.
*/
`timescale 1ns/1ps
`include "hdc_defs.svh"

module hdc_csr (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  csr_wr_i,
  input  logic                  csr_rd_i,
  input  hdc_pkg::csr_addr_t    csr_addr_i,
  input  hdc_pkg::csr_data_t    csr_wdata_i,
  output hdc_pkg::csr_data_t    csr_rdata_o,
  output logic                  csr_rvalid_o,
  input  logic                  running_i,
  input  hdc_pkg::inst_addr_t   pc_i,
  output logic                  run_o,
  output logic                  clr_o,
  output hdc_pkg::inst_addr_t   prog_end_o,
  output logic                  inst_we_o,
  output hdc_pkg::inst_addr_t   inst_waddr_o,
  output hdc_pkg::csr_data_t    inst_wdata_o
);

  import hdc_pkg::*;

  logic       run_q;
  logic       clr_q;
  inst_addr_t prog_end_q;
  inst_addr_t inst_addr_q;
  csr_data_t  rd_data;
  csr_data_t  rdata_q;
  logic       rvalid_q;

  // --------------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_q       <= 1'b0;
      clr_q       <= 1'b0;
      prog_end_q  <= '0;
      inst_addr_q <= '0;
    end else begin
      // Clear is a single-cycle pulse
      clr_q <= csr_wr_i && (csr_addr_i == `HDC_CSR_CTRL) && csr_wdata_i[1];
      if (csr_wr_i) begin
        case (csr_addr_i)
          `HDC_CSR_CTRL:      run_q       <= csr_wdata_i[0];
          `HDC_CSR_PROG_END:  prog_end_q  <= csr_wdata_i[`HDC_INST_ADDR_W-1:0];
          `HDC_CSR_INST_ADDR: inst_addr_q <= csr_wdata_i[`HDC_INST_ADDR_W-1:0];
          // Pointer wraps at the end of program memory
          `HDC_CSR_INST_DATA: inst_addr_q <= inst_addr_q + 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Program word goes straight to instruction memory
  assign inst_we_o    = csr_wr_i && (csr_addr_i == `HDC_CSR_INST_DATA);
  assign inst_waddr_o = inst_addr_q;
  assign inst_wdata_o = csr_wdata_i;

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------
  always_comb begin
    rd_data = '0;
    case (csr_addr_i)
      `HDC_CSR_CTRL:      rd_data[0] = run_q;
      `HDC_CSR_PROG_END:  rd_data[`HDC_INST_ADDR_W-1:0] = prog_end_q;
      `HDC_CSR_INST_ADDR: rd_data[`HDC_INST_ADDR_W-1:0] = inst_addr_q;
      `HDC_CSR_STATUS: begin
        rd_data[0] = running_i;
        rd_data[4 +: `HDC_INST_ADDR_W] = pc_i;
      end
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_q  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= csr_rd_i;
      if (csr_rd_i) begin
        rdata_q <= rd_data;
      end
    end
  end

  assign csr_rdata_o  = rdata_q;
  assign csr_rvalid_o = rvalid_q;
  assign run_o        = run_q;
  assign clr_o        = clr_q;
  assign prog_end_o   = prog_end_q;

endmodule

//--- src/hdc_pkg.sv
/*
  Common types of the HDC encoder: hypervector, CSR data and address fields,
  register and symbol widths, and the opcode set of the instruction word.
  Compile before any module of the core.
*/
package hdc_pkg;

  `include "hdc_defs.svh"

  typedef logic [`HDC_HV_DIM-1:0]      hv_t;
  typedef logic [`HDC_DATA_W-1:0]      csr_data_t;
  typedef logic [`HDC_CSR_ADDR_W-1:0]  csr_addr_t;
  typedef logic [`HDC_INST_ADDR_W-1:0] inst_addr_t;
  typedef logic [`HDC_REG_ADDR_W-1:0]  reg_addr_t;
  typedef logic [`HDC_SYM_W-1:0]       sym_t;

  // Opcodes, bits 2..0 of the instruction word
  // Encoding 7 is unused and decodes as a no-op
  typedef enum logic [2:0] {
    OP_NOP      = 3'd0,
    OP_LOAD_IM  = 3'd1,
    OP_BIND_IM  = 3'd2,
    OP_BIND_REG = 3'd3,
    OP_PERM     = 3'd4,
    OP_BUNDLE   = 3'd5,
    OP_EMIT     = 3'd6
  } hdc_op_e;

endpackage

//--- src/hdc_defs.svh
/*
  Shared sizes, CSR register addresses and the item seed of the HDC encoder.
  Include this header wherever one of these constants is needed.
*/
`ifndef HDC_DEFS_SVH
`define HDC_DEFS_SVH

// Datapath and program sizes
`define HDC_HV_DIM        64
`define HDC_DATA_W        32
`define HDC_CSR_ADDR_W    3
`define HDC_INST_DEPTH    16
`define HDC_INST_ADDR_W   4
`define HDC_NUM_REGS      4
`define HDC_REG_ADDR_W    2
`define HDC_SYM_W         6
`define HDC_BUND_W        8

// Base vector, rotated left by the symbol value
`define HDC_ITEM_SEED     64'hA5C3_96E1_0F7B_24D9

// CSR map
`define HDC_CSR_CTRL      3'd0
`define HDC_CSR_PROG_END  3'd1
`define HDC_CSR_INST_ADDR 3'd2
`define HDC_CSR_INST_DATA 3'd3
`define HDC_CSR_STATUS    3'd4

`endif
